// ==== logic/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	// Data path and field widths fixed by the architecture
	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [4:0] shamt_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI
	} alu_op_t;

	// Primary opcode field, instr[31:26]
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_SLTI  = 6'h0a;
	localparam logic [5:0] OP_SLTIU = 6'h0b;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_XORI  = 6'h0e;
	localparam logic [5:0] OP_LUI   = 6'h0f;

	// Funct field for R-type, instr[5:0]
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage

`default_nettype wire

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input wire clk,
	input wire rst,
	input wire write_ena,
	input wire mips_pkg::reg_addr_t rs_addr,
	input wire mips_pkg::reg_addr_t rt_addr,
	input wire mips_pkg::reg_addr_t write_reg,
	input wire mips_pkg::word_t write_data,
	output mips_pkg::word_t rs_data,
	output mips_pkg::word_t rt_data
);

	import mips_pkg::*;

	// Register 0 has no storage so only 1..31 are kept
	word_t regs [1:31];

	logic write_live;

	// Writes to register 0 are simply dropped
	assign write_live = write_ena && (write_reg != '0);

	// One read port with the bypass from the write port in the same cycle
	function automatic word_t read_port(
		input reg_addr_t addr,
		input logic wr_live,
		input reg_addr_t wr_reg,
		input word_t wr_data
	);
		word_t value;
		if (addr == '0) begin
			value = '0;
		end else if (wr_live && (addr == wr_reg)) begin
			value = wr_data;
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_comb begin
		rs_data = read_port(rs_addr, write_live, write_reg, write_data);
	end

	always_comb begin
		rt_data = read_port(rt_addr, write_live, write_reg, write_data);
	end

	// Architectural state starts at zero after reset
	always_ff @(posedge clk) begin
		if (~rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_live) begin
			regs[write_reg] <= write_data;
		end
	end

endmodule

`default_nettype wire

// ==== logic/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
	input wire clk,
	input wire rst,
	input wire [31:0] instr,
	input wire instr_valid,
	input wire mips_pkg::word_t rs_data,
	input wire mips_pkg::word_t rt_data,
	output mips_pkg::reg_addr_t rs_addr,
	output mips_pkg::reg_addr_t rt_addr,
	output logic ex_valid,
	output logic ex_write,
	output mips_pkg::alu_op_t ex_op,
	output mips_pkg::word_t ex_a,
	output mips_pkg::word_t ex_b,
	output mips_pkg::shamt_t ex_shamt,
	output mips_pkg::reg_addr_t ex_dest
);

	import mips_pkg::*;

	// Instruction fields
	logic [5:0] opcode;
	logic [5:0] funct;
	logic [15:0] imm;
	reg_addr_t rd_field;
	shamt_t shamt_field;

	// Decoded controls
	alu_op_t dec_op;
	logic dec_write;
	logic dec_use_imm;
	logic dec_sign_ext;
	reg_addr_t dec_dest;
	word_t imm_ext;
	word_t operand_b;

	assign opcode      = instr[31:26];
	assign rs_addr     = instr[25:21];
	assign rt_addr     = instr[20:16];
	assign rd_field    = instr[15:11];
	assign shamt_field = instr[10:6];
	assign funct       = instr[5:0];
	assign imm         = instr[15:0];

	always_comb begin
		dec_op       = ALU_ADD;
		dec_write    = 1'b0;
		dec_use_imm  = 1'b0;
		dec_sign_ext = 1'b1;
		dec_dest     = rt_addr;
		case (opcode)
			OP_RTYPE: begin
				dec_dest  = rd_field;
				dec_write = 1'b1;
				case (funct)
					FN_SLL:  dec_op = ALU_SLL;
					FN_SRL:  dec_op = ALU_SRL;
					FN_SRA:  dec_op = ALU_SRA;
					FN_ADDU: dec_op = ALU_ADD;
					FN_SUBU: dec_op = ALU_SUB;
					FN_AND:  dec_op = ALU_AND;
					FN_OR:   dec_op = ALU_OR;
					FN_XOR:  dec_op = ALU_XOR;
					FN_NOR:  dec_op = ALU_NOR;
					FN_SLT:  dec_op = ALU_SLT;
					FN_SLTU: dec_op = ALU_SLTU;
					// Unknown funct retires with no write-back
					default: dec_write = 1'b0;
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				dec_write   = 1'b1;
				dec_use_imm = 1'b1;
				dec_op      = (opcode == OP_ADDIU) ? ALU_ADD :
				              (opcode == OP_SLTI) ? ALU_SLT : ALU_SLTU;
			end
			OP_ANDI, OP_ORI, OP_XORI: begin
				// Logical immediates are zero extended
				dec_write    = 1'b1;
				dec_use_imm  = 1'b1;
				dec_sign_ext = 1'b0;
				dec_op       = (opcode == OP_ANDI) ? ALU_AND :
				               (opcode == OP_ORI) ? ALU_OR : ALU_XOR;
			end
			OP_LUI: begin
				dec_write    = 1'b1;
				dec_use_imm  = 1'b1;
				dec_sign_ext = 1'b0;
				dec_op       = ALU_LUI;
			end
			default: begin
				dec_write = 1'b0;
			end
		endcase
	end

	assign imm_ext   = dec_sign_ext ? {{16{imm[15]}}, imm} : {16'b0, imm};
	assign operand_b = dec_use_imm ? imm_ext : rt_data;

	// Control bits of the issue register
	always_ff @(posedge clk) begin
		if (~rst) begin
			ex_valid <= 1'b0;
			ex_write <= 1'b0;
		end else begin
			ex_valid <= instr_valid;
			if (instr_valid) begin
				ex_write <= dec_write;
			end
		end
	end

	// Payload only loads on a valid instruction
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			ex_op    <= dec_op;
			ex_a     <= rs_data;
			ex_b     <= operand_b;
			ex_shamt <= shamt_field;
			ex_dest  <= dec_dest;
		end
	end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire mips_pkg::alu_op_t op,
	input wire mips_pkg::word_t a,
	input wire mips_pkg::word_t b,
	input wire mips_pkg::shamt_t shamt,
	output mips_pkg::word_t result
);

	import mips_pkg::*;

	logic lt_signed;
	logic lt_unsigned;

	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			ALU_ADD: begin
				result = a + b;
			end
			ALU_SUB: begin
				result = a - b;
			end
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			ALU_XOR: begin
				result = a ^ b;
			end
			ALU_NOR: begin
				result = ~(a | b);
			end
			ALU_SLT: begin
				result = {31'b0, lt_signed};
			end
			ALU_SLTU: begin
				result = {31'b0, lt_unsigned};
			end
			// Shifts work on the rt operand
			ALU_SLL: begin
				result = b << shamt;
			end
			ALU_SRL: begin
				result = b >> shamt;
			end
			ALU_SRA: begin
				result = word_t'($signed(b) >>> shamt);
			end
			ALU_LUI: begin
				result = {b[15:0], 16'b0};
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/int_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_core (
	input wire clk,
	input wire rst,
	input wire [31:0] instr,
	input wire instr_valid,
	output wire wb_valid,
	output wire mips_pkg::reg_addr_t wb_reg,
	output wire mips_pkg::word_t wb_data
);

	import mips_pkg::*;

	// Decode side
	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	word_t rs_data;
	word_t rt_data;

	// Execute side
	logic ex_valid;
	logic ex_write;
	alu_op_t ex_op;
	word_t ex_a;
	word_t ex_b;
	shamt_t ex_shamt;
	reg_addr_t ex_dest;
	word_t result;
	logic write_ena;

	// Unsupported encodings travel down the pipe but never write
	assign write_ena = ex_valid & ex_write;

	issue_stage i_issue_stage (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.rs_data     (rs_data),
		.rt_data     (rt_data),
		.rs_addr     (rs_addr),
		.rt_addr     (rt_addr),
		.ex_valid    (ex_valid),
		.ex_write    (ex_write),
		.ex_op       (ex_op),
		.ex_a        (ex_a),
		.ex_b        (ex_b),
		.ex_shamt    (ex_shamt),
		.ex_dest     (ex_dest)
	);

	register_file i_register_file (
		.clk        (clk),
		.rst        (rst),
		.write_ena  (write_ena),
		.rs_addr    (rs_addr),
		.rt_addr    (rt_addr),
		.write_reg  (ex_dest),
		.write_data (result),
		.rs_data    (rs_data),
		.rt_data    (rt_data)
	);

	alu i_alu (
		.op     (ex_op),
		.a      (ex_a),
		.b      (ex_b),
		.shamt  (ex_shamt),
		.result (result)
	);

	// Outputs mirror the register file write port
	assign wb_valid = write_ena;
	assign wb_reg   = ex_dest;
	assign wb_data  = result;

endmodule

`default_nettype wire

// ==== verif/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
	output logic clk,
	output logic rst
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// Active low reset held over the first three rising edges
	initial begin
		rst = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== verif/tb_int_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_int_core;

	import mips_pkg::*;

	logic clk;
	logic rst;
	logic [31:0] instr;
	logic instr_valid;
	logic wb_valid;
	reg_addr_t wb_reg;
	word_t wb_data;

	// Stimulus table with the expected write-back of each entry
	logic [31:0] tbl_instr [$];
	logic tbl_valid [$];
	logic exp_valid [$];
	reg_addr_t exp_reg [$];
	word_t exp_data [$];

	// Architectural registers in program order
	word_t shadow [0:31];
	logic [5:0] funct_list [0:10];
	logic [5:0] imm_ops [0:6];
	logic table_ready = 1'b0;

	clk_gen i_clk_gen (
		.clk (clk),
		.rst (rst)
	);

	int_core i_dut (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.wb_valid    (wb_valid),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data)
	);

	function automatic logic [31:0] r_word(logic [5:0] fn, reg_addr_t rd, reg_addr_t rs,
			reg_addr_t rt, shamt_t sh);
		return {OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] i_word(logic [5:0] op, reg_addr_t rt, reg_addr_t rs,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Any register but zero
	function automatic reg_addr_t rand_reg();
		word_t r;
		r = ($urandom % 31) + 1;
		return r[4:0];
	endfunction

	function automatic logic [15:0] rand_half();
		word_t r;
		r = $urandom;
		return r[15:0];
	endfunction

	// Reference model that executes one entry against the shadow registers
	task automatic push_entry(logic [31:0] word, logic valid);
		word_t a;
		word_t b;
		word_t sx;
		word_t zx;
		word_t val;
		reg_addr_t dst;
		logic wr;
		a = shadow[word[25:21]];
		b = shadow[word[20:16]];
		sx = {{16{word[15]}}, word[15:0]};
		zx = {16'h0000, word[15:0]};
		dst = word[20:16];
		val = '0;
		wr = valid;
		case (word[31:26])
			OP_RTYPE: begin
				dst = word[15:11];
				case (word[5:0])
					FN_ADDU: val = a + b;
					FN_SUBU: val = a - b;
					FN_AND:  val = a & b;
					FN_OR:   val = a | b;
					FN_XOR:  val = a ^ b;
					FN_NOR:  val = ~(a | b);
					FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					FN_SLTU: val = (a < b) ? 32'd1 : 32'd0;
					FN_SLL:  val = b << word[10:6];
					FN_SRL:  val = b >> word[10:6];
					FN_SRA:  val = $signed(b) >>> word[10:6];
					default: wr = 1'b0;
				endcase
			end
			OP_ADDIU: val = a + sx;
			OP_SLTI:  val = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
			OP_SLTIU: val = (a < sx) ? 32'd1 : 32'd0;
			OP_ANDI:  val = a & zx;
			OP_ORI:   val = a | zx;
			OP_XORI:  val = a ^ zx;
			OP_LUI:   val = {word[15:0], 16'h0000};
			default:  wr = 1'b0;
		endcase
		if (wr && (dst != 5'd0)) begin
			shadow[dst] = val;
		end
		tbl_instr.push_back(word);
		tbl_valid.push_back(valid);
		exp_valid.push_back(wr);
		exp_reg.push_back(dst);
		exp_data.push_back(val);
	endtask

	task automatic build_table();
		reg_addr_t d;
		reg_addr_t prev;
		logic [5:0] fn;
		for (int r = 0; r < 32; r++) begin
			shadow[r] = '0;
		end
		funct_list = '{FN_SLL, FN_SRL, FN_SRA, FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
			FN_NOR, FN_SLT, FN_SLTU};
		imm_ops = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
		// First instruction sees cleared registers
		push_entry(r_word(FN_OR, rand_reg(), rand_reg(), rand_reg(), 5'd0), 1'b1);
		// Random contents everywhere with about half of them negative
		for (int r = 1; r < 32; r++) begin
			push_entry(i_word(OP_LUI, r[4:0], 5'd0, rand_half()), 1'b1);
			push_entry(i_word(OP_ORI, r[4:0], r[4:0], rand_half()), 1'b1);
		end
		for (int k = 0; k < 42; k++) begin
			push_entry(i_word(imm_ops[k % 7], rand_reg(), rand_reg(), rand_half()), 1'b1);
		end
		// Shifts keep rs at zero and use a random shift amount
		for (int k = 0; k < 66; k++) begin
			d = (k % 11 < 3) ? 5'd0 : rand_reg();
			push_entry(r_word(funct_list[k % 11], rand_reg(), d, rand_reg(),
				(k % 11 < 3) ? rand_reg() : 5'd0), 1'b1);
		end
		// Each one reads the result of the one before
		// R-type entries alternate the bypassed read port between rs and rt
		prev = rand_reg();
		for (int k = 0; k < 20; k++) begin
			d = rand_reg();
			if (k % 2 == 0) begin
				fn = funct_list[3 + (k / 2) % 8];
				if ((k / 2) % 2 == 0) begin
					push_entry(r_word(fn, d, prev, rand_reg(), 5'd0), 1'b1);
				end else begin
					push_entry(r_word(fn, d, rand_reg(), prev, 5'd0), 1'b1);
				end
			end else begin
				push_entry(i_word(OP_ADDIU, d, prev, rand_half()), 1'b1);
			end
			prev = d;
		end
		push_entry(i_word(OP_ADDIU, 5'd0, rand_reg(), rand_half()), 1'b1);
		push_entry(r_word(FN_ADDU, 5'd0, rand_reg(), rand_reg(), 5'd0), 1'b1);
		push_entry(i_word(OP_ORI, rand_reg(), 5'd0, 16'h1234), 1'b1);
		push_entry(r_word(FN_OR, rand_reg(), 5'd0, 5'd0, 5'd0), 1'b1);
		// Bubble, lw opcode and mult funct must all leave d alone
		for (int k = 0; k < 4; k++) begin
			d = rand_reg();
			push_entry(i_word(OP_ADDIU, d, d, rand_half()), 1'b1);
			push_entry(i_word(OP_LUI, d, 5'd0, rand_half()), 1'b0);
			push_entry(i_word(6'h23, d, rand_reg(), rand_half()), 1'b1);
			push_entry(r_word(6'h18, d, rand_reg(), rand_reg(), 5'd0), 1'b1);
			push_entry(r_word(FN_OR, rand_reg(), d, 5'd0, 5'd0), 1'b1);
		end
	endtask

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare_writeback(int idx);
		assert (wb_valid === exp_valid[idx]) else report_failure($sformatf(
			"mismatch wb_valid entry %0d: got %h expected %h", idx, wb_valid, exp_valid[idx]));
		if (exp_valid[idx]) begin
			assert (wb_reg === exp_reg[idx]) else report_failure($sformatf(
				"mismatch wb_reg entry %0d: got %h expected %h", idx, wb_reg, exp_reg[idx]));
			assert (wb_data === exp_data[idx]) else report_failure($sformatf(
				"mismatch wb_data entry %0d: got %h expected %h", idx, wb_data, exp_data[idx]));
		end
	endtask

	initial begin
		int n;
		instr = '0;
		instr_valid = 1'b0;
		void'($urandom(32'hede8c0dc));
		build_table();
		n = tbl_instr.size();
		table_ready = 1'b1;
		wait (rst === 1'b1);
		@(negedge clk);
		assert (wb_valid === 1'b0) else report_failure($sformatf(
			"mismatch wb_valid after reset: got %h expected %h", wb_valid, 1'b0));
		// Entry i goes in on one edge and is checked after the next
		for (int i = 0; i <= n; i++) begin
			@(posedge clk);
			if (i < n) begin
				instr <= tbl_instr[i];
				instr_valid <= tbl_valid[i];
			end else begin
				instr <= '0;
				instr_valid <= 1'b0;
			end
			@(negedge clk);
			if (i > 0) begin
				compare_writeback(i - 1);
			end
		end
		$display("TEST PASS");
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		int limit_ns;
		wait (table_ready);
		limit_ns = (tbl_instr.size() + 20) * 10;
		#(limit_ns);
		$display("timeout: the write-back checks did not finish in time");
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/mips_pkg.sv
logic/register_file.sv
logic/issue_stage.sv
logic/alu.sv
logic/int_core.sv
verif/clk_gen.sv
verif/tb_int_core.sv

// ==== Bender.yml ====
package:
  name: int_core

sources:
  - logic/mips_pkg.sv
  - logic/register_file.sv
  - logic/issue_stage.sv
  - logic/alu.sv
  - logic/int_core.sv
  - target: test
    files:
      - verif/clk_gen.sv
      - verif/tb_int_core.sv
